/* filelist.f */
+incdir+logic
logic/c16_isa_pkg.sv
logic/c16_core_pkg.sv
logic/c16_decoder.sv
logic/c16_execute_unit.sv
logic/c16_reorder_buffer.sv
logic/c16_core.sv
verification/c16_core_chk.sv
verification/c16_core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the c16_core testbench with Verilator and run it.
# The exit status is nonzero when the build fails or the testbench stops with $fatal.

cd "$(dirname "$0")" \
	&& verilator --binary --assert -f filelist.f --top-module c16_core_tb -o c16_core_sim \
	&& ./obj_dir/c16_core_sim \
	|| { echo "Simulation did not pass"; exit 1; }

exit 0

/* verification/c16_core_tb.sv */
`timescale 1ns/10ps
`include "c16_config.svh"

module c16_core_tb;

	localparam int CLK_PERIOD = 100;
	localparam int NUM_INSTR = 12 + 12 + 9 + 40 + 6;
	localparam int WATCHDOG_CYCLES = NUM_INSTR * 40 + 10;

	logic                   clk;
	logic                   rst_n;
	logic                   instr_req;
	logic                   instr_ack;
	c16_isa_pkg::instr_u    instr;
	c16_core_pkg::commit_t  commit;
	c16_isa_pkg::reg_idx_t  arch_read_addr;
	logic [`C16_DATA_W-1:0] arch_read_value;

	logic [`C16_DATA_W-1:0] model_regs [`C16_NUM_REGS];
	c16_core_pkg::commit_t  expected_q [$];

	c16_core c16_core_i (.*);

	bind c16_core c16_core_chk c16_core_chk_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.instr_req (instr_req),
		.instr_ack (instr_ack),
		.instr     (instr),
		.commit    (commit)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	//////////////////////////////
	// Reference model and checks
	//////////////////////////////

	// Sequential ISA semantics on the model registers
	function automatic c16_core_pkg::commit_t expected_commit(input c16_isa_pkg::instr_u w);
		c16_core_pkg::commit_t  exp;
		logic [`C16_DATA_W-1:0] a;
		logic [`C16_DATA_W-1:0] imm;
		exp = '0;
		a = model_regs[w.i_fmt.src_a];
		imm = `C16_DATA_W'($signed(w.i_fmt.imm)); // Two's complement field
		exp.valid = 1'b1;
		exp.dest = w.i_fmt.dest;
		case (w.i_fmt.opcode)
			c16_isa_pkg::ADD_IMM: exp.value = a + imm;
			c16_isa_pkg::ADD_REG: exp.value = a + model_regs[w.r_fmt.src_b];
			c16_isa_pkg::SUB_IMM: exp.value = a - imm;
			c16_isa_pkg::SUB_REG: exp.value = a - model_regs[w.r_fmt.src_b];
			default: exp = '0; // Illegal words retire nothing
		endcase
		if (exp.valid) begin
			model_regs[exp.dest] = exp.value;
		end
		return exp;
	endfunction

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Errors found");
		$fatal(1, "Simulation stopped on the first error");
	endtask

	task automatic check_commit(input c16_core_pkg::commit_t got,
			input c16_core_pkg::commit_t exp);
		if (got.dest !== exp.dest || got.value !== exp.value) begin
			abort_run($sformatf("FAILED at %0t: commit r%0d = %h, expected r%0d = %h",
				$time, got.dest, got.value, exp.dest, exp.value));
		end
	endtask

	task automatic check_reg(input c16_isa_pkg::reg_idx_t addr,
			input logic [`C16_DATA_W-1:0] got, input logic [`C16_DATA_W-1:0] exp);
		if (got !== exp) begin
			abort_run($sformatf("FAILED at %0t: committed r%0d reads %h, expected %h",
				$time, addr, got, exp));
		end
	endtask

	//////////////////////////////
	// Stimulus helpers
	//////////////////////////////

	function automatic c16_isa_pkg::instr_u make_imm_instr(input c16_isa_pkg::opcode_e op,
			input c16_isa_pkg::reg_idx_t dest, input c16_isa_pkg::reg_idx_t src_a,
			input logic [4:0] imm);
		c16_isa_pkg::instr_u w;
		w.i_fmt = '{opcode: op, dest: dest, src_a: src_a, imm: imm};
		return w;
	endfunction

	function automatic c16_isa_pkg::instr_u make_reg_instr(input c16_isa_pkg::opcode_e op,
			input c16_isa_pkg::reg_idx_t dest, input c16_isa_pkg::reg_idx_t src_a,
			input c16_isa_pkg::reg_idx_t src_b);
		c16_isa_pkg::instr_u w;
		w.r_fmt = '{opcode: op, dest: dest, src_a: src_a, unused: 2'b00, src_b: src_b};
		return w;
	endfunction

	// Half of them read the previous destination
	function automatic c16_isa_pkg::instr_u random_instr(input c16_isa_pkg::reg_idx_t prev);
		c16_isa_pkg::instr_u w;
		w = 16'($urandom);
		w.i_fmt.opcode = c16_isa_pkg::opcode_e'(5'($urandom_range(3, 0)));
		if ($urandom_range(1, 0) == 1) begin
			w.i_fmt.src_a = prev;
		end
		return w;
	endfunction

	function automatic c16_isa_pkg::instr_u illegal_instr();
		c16_isa_pkg::instr_u w;
		w = 16'($urandom);
		w[15:11] = 5'($urandom_range(31, 4));
		return w;
	endfunction

	// Four-phase handshake entered and left 10 ns after a rising edge
	task automatic drive_instr(input c16_isa_pkg::instr_u word);
		c16_core_pkg::commit_t exp;
		exp = expected_commit(word);
		if (exp.valid) begin
			expected_q.push_back(exp);
		end
		instr = word;
		instr_req = 1'b1;
		while (!instr_ack) begin
			@(posedge clk);
			#10;
		end
		instr_req = 1'b0;
		while (instr_ack) begin
			@(posedge clk);
			#10;
		end
	endtask

	//////////////////////////////
	// Compare and watchdog
	//////////////////////////////

	always @(negedge clk) begin
		if (rst_n && commit.valid) begin
			if (expected_q.size() == 0) begin
				abort_run("A commit arrived while no instruction was expected");
			end else begin
				check_commit(commit, expected_q.pop_front());
			end
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		abort_run("Timeout: the core stopped before all expected commits arrived");
	end

	//////////////////////////////
	// Test sequence
	//////////////////////////////

	initial begin
		c16_isa_pkg::reg_idx_t prev;
		c16_isa_pkg::reg_idx_t dest;
		c16_isa_pkg::opcode_e  op;
		c16_isa_pkg::instr_u   w;
		void'($urandom(32'h71d));
		rst_n = 1'b0;
		instr_req = 1'b0;
		instr = '0;
		arch_read_addr = '0;
		for (int r = 0; r < `C16_NUM_REGS; r++) begin
			model_regs[r] = '0;
		end
		repeat (2) @(posedge clk);
		#10;
		rst_n = 1'b1;

		for (int i = 0; i < 12; i++) begin // Negative immediates
			op = ($urandom_range(1, 0) == 1) ? c16_isa_pkg::ADD_IMM : c16_isa_pkg::SUB_IMM;
			drive_instr(make_imm_instr(op, 3'($urandom), 3'($urandom), {1'b1, 4'($urandom)}));
		end

		for (int c = 0; c < 2; c++) begin // Register-form chains
			prev = 3'($urandom);
			for (int k = 0; k < 6; k++) begin
				dest = 3'($urandom);
				op = ($urandom_range(1, 0) == 1) ? c16_isa_pkg::ADD_REG : c16_isa_pkg::SUB_REG;
				drive_instr(make_reg_instr(op, dest, prev, 3'($urandom)));
				prev = dest;
			end
		end

		for (int k = 0; k < 8; k++) begin
			op = k[0] ? c16_isa_pkg::SUB_REG : c16_isa_pkg::ADD_REG;
			drive_instr(make_reg_instr(op, 3'd3, 3'd3, 3'd5));
		end
		drive_instr(make_imm_instr(c16_isa_pkg::ADD_IMM, 3'd6, 3'd7, 5'd9)); // Independent

		prev = 3'd0;
		for (int i = 0; i < 40; i++) begin // Burst
			w = random_instr(prev);
			drive_instr(w);
			prev = w.i_fmt.dest;
		end

		for (int k = 0; k < 6; k++) begin
			if (k == 2 || k == 4) begin
				drive_instr(random_instr(prev));
			end else begin
				drive_instr(illegal_instr());
			end
		end

		while (expected_q.size() != 0) begin
			@(negedge clk);
		end
		for (int r = 0; r < `C16_NUM_REGS; r++) begin
			@(posedge clk);
			#10;
			arch_read_addr = 3'(r);
			@(negedge clk);
			check_reg(3'(r), arch_read_value, model_regs[r]);
		end

		$display("No errors");
		$finish;
	end

endmodule

/* verification/c16_core_chk.sv */
`timescale 1ns/10ps

module c16_core_chk (
	input logic                  clk,
	input logic                  rst_n,
	input logic                  instr_req,
	input logic                  instr_ack,
	input c16_isa_pkg::instr_u   instr,
	input c16_core_pkg::commit_t commit
);

	logic       ack_q;
	logic       legal;
	logic [3:0] in_flight; // Acked legal words not yet retired

	assign legal = (instr.i_fmt.opcode[4:2] == 3'b000);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ack_q <= 1'b0;
			in_flight <= '0;
		end else begin
			ack_q <= instr_ack;
			in_flight <= in_flight + 4'(instr_ack && !ack_q && legal) - 4'(commit.valid);
		end
	end

	//////////////////////////////
	// Handshake
	//////////////////////////////

	ack_rise_with_req: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(instr_ack) |-> $past(instr_req))
		else $error("instr_ack rose without instr_req");

	ack_fall_after_req: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(instr_ack) |-> !$past(instr_req))
		else $error("instr_ack fell while instr_req was high");

	//////////////////////////////
	// Commit
	//////////////////////////////

	commit_needs_entry: assert property (@(posedge clk) disable iff (!rst_n)
		commit.valid |-> in_flight != 4'd0)
		else $error("commit_valid with an empty reorder buffer");

	commit_single_when_last: assert property (@(posedge clk) disable iff (!rst_n)
		commit.valid && in_flight == 4'd1 |=> !commit.valid)
		else $error("commit_valid held after the last entry retired");

endmodule

/* logic/c16_core.sv */
`timescale 1ns/10ps
`include "c16_config.svh"

module c16_core (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   instr_req,
	output logic                   instr_ack,
	input  c16_isa_pkg::instr_u    instr,
	output c16_core_pkg::commit_t  commit,
	input  c16_isa_pkg::reg_idx_t  arch_read_addr,
	output logic [`C16_DATA_W-1:0] arch_read_value
);

	// Decoder to execute
	logic                  dispatch_valid;
	c16_core_pkg::uop_t    dispatch;
	logic                  station_full;

	// Decoder to reorder buffer
	logic                  alloc_valid;
	c16_isa_pkg::reg_idx_t alloc_dest;
	c16_core_pkg::tag_t    rob_tail;
	logic                  rob_full;

	c16_core_pkg::result_t result; // Seen by all three stages

	c16_decoder c16_decoder_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.instr_req      (instr_req),
		.instr_ack      (instr_ack),
		.instr          (instr),
		.station_full   (station_full),
		.rob_full       (rob_full),
		.rob_tail       (rob_tail),
		.result         (result),
		.dispatch_valid (dispatch_valid),
		.dispatch       (dispatch),
		.alloc_valid    (alloc_valid),
		.alloc_dest     (alloc_dest)
	);

	c16_execute_unit c16_execute_unit_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.dispatch_valid (dispatch_valid),
		.dispatch       (dispatch),
		.station_full   (station_full),
		.result         (result)
	);

	c16_reorder_buffer c16_reorder_buffer_i (
		.clk             (clk),
		.rst_n           (rst_n),
		.alloc_valid     (alloc_valid),
		.alloc_dest      (alloc_dest),
		.rob_tail        (rob_tail),
		.rob_full        (rob_full),
		.result          (result),
		.commit          (commit),
		.arch_read_addr  (arch_read_addr),
		.arch_read_value (arch_read_value)
	);

endmodule

/* logic/c16_reorder_buffer.sv */
`timescale 1ns/10ps
`include "c16_config.svh"

module c16_reorder_buffer (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   alloc_valid,
	input  c16_isa_pkg::reg_idx_t  alloc_dest,
	output c16_core_pkg::tag_t     rob_tail,
	output logic                   rob_full,
	input  c16_core_pkg::result_t  result,
	output c16_core_pkg::commit_t  commit,
	input  c16_isa_pkg::reg_idx_t  arch_read_addr,
	output logic [`C16_DATA_W-1:0] arch_read_value
);

	localparam int DEPTH = `C16_ROB_DEPTH;
	localparam int CNT_W = $clog2(DEPTH + 1);

	c16_isa_pkg::reg_idx_t  slot_dest [DEPTH];
	logic [`C16_DATA_W-1:0] slot_value [DEPTH];
	logic [DEPTH-1:0]       slot_done;

	c16_core_pkg::tag_t head;
	c16_core_pkg::tag_t tail;
	logic [CNT_W-1:0]   count;
	logic               retire;

	logic [`C16_DATA_W-1:0] arch_regs [`C16_NUM_REGS];

	assign rob_tail = tail;
	assign rob_full = (count == CNT_W'(DEPTH));

	// Head leaves once its result is in
	assign retire = (count != '0) && slot_done[head];
	assign commit = '{valid: retire, dest: slot_dest[head], value: slot_value[head]};

	//////////////////////////////
	// Circular buffer
	//////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			head <= '0;
			tail <= '0;
			count <= '0;
			slot_done <= '0;
		end else begin
			if (alloc_valid) begin
				slot_done[tail] <= 1'b0;
				tail <= tail + 1'b1;
			end
			if (result.valid) begin
				slot_done[result.tag] <= 1'b1;
			end
			if (retire) begin
				head <= head + 1'b1;
			end
			count <= count + CNT_W'(alloc_valid) - CNT_W'(retire);
		end
	end

	always_ff @(posedge clk) begin
		if (alloc_valid) begin
			slot_dest[tail] <= alloc_dest;
		end
		if (result.valid) begin
			slot_value[result.tag] <= result.value;
		end
	end

	//////////////////////////////
	// Committed register file
	//////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int r = 0; r < `C16_NUM_REGS; r++) begin
				arch_regs[r] <= '0;
			end
		end else if (retire) begin
			arch_regs[commit.dest] <= commit.value;
		end
	end

	// Commit in this cycle shows through at once
	assign arch_read_value = (retire && commit.dest == arch_read_addr)
		? commit.value
		: arch_regs[arch_read_addr];

endmodule

/* logic/c16_execute_unit.sv */
`timescale 1ns/10ps
`include "c16_config.svh"

module c16_execute_unit (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  dispatch_valid,
	input  c16_core_pkg::uop_t    dispatch,
	output logic                  station_full,
	output c16_core_pkg::result_t result
);

	localparam int DEPTH = `C16_RS_DEPTH;
	localparam int IDX_W = $clog2(DEPTH);

	// Collapsing queue, slot 0 is the oldest
	logic [DEPTH-1:0]   ent_valid;
	c16_core_pkg::uop_t ent_uop [DEPTH];

	logic [DEPTH:0]     valid_ext;
	c16_core_pkg::uop_t woken [DEPTH+1]; // Top slot is a zero filler
	logic [DEPTH-1:0]   nxt_valid;
	c16_core_pkg::uop_t nxt_uop [DEPTH];

	logic               issue_hit;
	logic [IDX_W-1:0]   issue_idx;
	c16_core_pkg::uop_t issue_uop;
	logic [`C16_DATA_W-1:0] alu_out;

	logic                   res_valid;
	c16_core_pkg::tag_t     res_tag;
	logic [`C16_DATA_W-1:0] res_value;

	assign station_full = &ent_valid;
	assign valid_ext = {1'b0, ent_valid};

	//////////////////////////////
	// Wakeup and select
	//////////////////////////////

	always_comb begin
		for (int i = 0; i < DEPTH; i++) begin
			woken[i] = ent_uop[i];
			woken[i].src_a = c16_core_pkg::snoop(ent_uop[i].src_a, result);
			woken[i].src_b = c16_core_pkg::snoop(ent_uop[i].src_b, result);
		end
		woken[DEPTH] = '0;
	end

	// Lowest ready slot is the oldest
	always_comb begin
		issue_hit = 1'b0;
		issue_idx = '0;
		for (int i = DEPTH - 1; i >= 0; i--) begin
			if (ent_valid[i] && ent_uop[i].src_a.ready && ent_uop[i].src_b.ready) begin
				issue_hit = 1'b1;
				issue_idx = IDX_W'(i);
			end
		end
	end

	assign issue_uop = ent_uop[issue_idx];

	//////////////////////////////
	// Station update
	//////////////////////////////

	always_comb begin
		logic placed;
		placed = 1'b0;
		for (int i = 0; i < DEPTH; i++) begin
			if (issue_hit && IDX_W'(i) >= issue_idx) begin // Close the gap
				nxt_valid[i] = valid_ext[i + 1];
				nxt_uop[i] = woken[i + 1];
			end else begin
				nxt_valid[i] = valid_ext[i];
				nxt_uop[i] = woken[i];
			end
			if (dispatch_valid && !placed && !nxt_valid[i]) begin
				nxt_valid[i] = 1'b1;
				nxt_uop[i] = dispatch;
				placed = 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ent_valid <= '0;
		end else begin
			ent_valid <= nxt_valid;
		end
	end

	always_ff @(posedge clk) begin
		ent_uop <= nxt_uop;
	end

	//////////////////////////////
	// Add/subtract stage
	//////////////////////////////

	assign alu_out = (issue_uop.alu_op == c16_core_pkg::SUB)
		? issue_uop.src_a.data - issue_uop.src_b.data
		: issue_uop.src_a.data + issue_uop.src_b.data;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			res_valid <= 1'b0;
		end else begin
			res_valid <= issue_hit;
		end
	end

	always_ff @(posedge clk) begin
		if (issue_hit) begin
			res_tag <= issue_uop.tag;
			res_value <= alu_out;
		end
	end

	assign result = '{valid: res_valid, tag: res_tag, value: res_value};

endmodule

/* logic/c16_decoder.sv */
`timescale 1ns/10ps
`include "c16_config.svh"

module c16_decoder (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  instr_req,
	output logic                  instr_ack,
	input  c16_isa_pkg::instr_u   instr,
	input  logic                  station_full,
	input  logic                  rob_full,
	input  c16_core_pkg::tag_t    rob_tail,
	input  c16_core_pkg::result_t result,
	output logic                  dispatch_valid,
	output c16_core_pkg::uop_t    dispatch,
	output logic                  alloc_valid,
	output c16_isa_pkg::reg_idx_t alloc_dest
);

	// Per register, value or producer tag
	c16_core_pkg::operand_t rename_tbl [`C16_NUM_REGS];

	logic                   accept;
	logic                   legal;
	logic                   reg_form;
	logic [`C16_DATA_W-1:0] imm_ext;

	//////////////////////////////
	// Decode and operand read
	//////////////////////////////

	assign imm_ext = {{(`C16_DATA_W - 5){instr.i_fmt.imm[4]}}, instr.i_fmt.imm};

	always_comb begin
		legal = 1'b1;
		reg_form = 1'b0;
		dispatch.alu_op = c16_core_pkg::ADD;
		case (instr.i_fmt.opcode)
			c16_isa_pkg::ADD_IMM: begin
				reg_form = 1'b0;
			end
			c16_isa_pkg::ADD_REG: begin
				reg_form = 1'b1;
			end
			c16_isa_pkg::SUB_IMM: begin
				dispatch.alu_op = c16_core_pkg::SUB;
			end
			c16_isa_pkg::SUB_REG: begin
				dispatch.alu_op = c16_core_pkg::SUB;
				reg_form = 1'b1;
			end
			default: legal = 1'b0;
		endcase

		dispatch.tag = rob_tail;
		dispatch.src_a = c16_core_pkg::snoop(rename_tbl[instr.i_fmt.src_a], result);
		if (reg_form) begin
			dispatch.src_b = c16_core_pkg::snoop(rename_tbl[instr.r_fmt.src_b], result);
		end else begin
			dispatch.src_b.ready = 1'b1;
			dispatch.src_b.data = imm_ext;
		end
	end

	//////////////////////////////
	// Handshake
	//////////////////////////////

	assign accept = instr_req && !instr_ack && !station_full && !rob_full;
	assign dispatch_valid = accept && legal;
	assign alloc_valid = dispatch_valid; // Illegal words only get acked
	assign alloc_dest = instr.i_fmt.dest;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			instr_ack <= 1'b0;
		end else if (accept) begin
			instr_ack <= 1'b1;
		end else if (!instr_req) begin
			instr_ack <= 1'b0;
		end
	end

	//////////////////////////////
	// Rename table
	//////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int r = 0; r < `C16_NUM_REGS; r++) begin
				rename_tbl[r].ready <= 1'b1;
				rename_tbl[r].data <= '0;
			end
		end else begin
			for (int r = 0; r < `C16_NUM_REGS; r++) begin
				rename_tbl[r] <= c16_core_pkg::snoop(rename_tbl[r], result);
			end
			if (alloc_valid) begin // New claim overrides the wakeup
				rename_tbl[alloc_dest].ready <= 1'b0;
				rename_tbl[alloc_dest].data <=
					{{(`C16_DATA_W - c16_core_pkg::TAG_W){1'b0}}, rob_tail};
			end
		end
	end

endmodule

/* logic/c16_core_pkg.sv */
`include "c16_config.svh"

package c16_core_pkg;

	localparam int TAG_W = $clog2(`C16_ROB_DEPTH);

	typedef logic [TAG_W-1:0] tag_t; // Reorder slot index

	typedef enum logic {ADD, SUB} alu_op_e;

	// Value when ready, producer tag in the low bits otherwise
	typedef struct packed {
		logic                   ready;
		logic [`C16_DATA_W-1:0] data;
	} operand_t;

	typedef struct packed {
		alu_op_e  alu_op;
		tag_t     tag;
		operand_t src_a;
		operand_t src_b;
	} uop_t;

	// Broadcast bus
	typedef struct packed {
		logic                   valid;
		tag_t                   tag;
		logic [`C16_DATA_W-1:0] value;
	} result_t;

	typedef struct packed {
		logic                   valid;
		c16_isa_pkg::reg_idx_t  dest;
		logic [`C16_DATA_W-1:0] value;
	} commit_t;

	// Wake a waiting operand from the result bus
	function automatic operand_t snoop(input operand_t op, input result_t res);
		operand_t woke;
		woke = op;
		if (!op.ready && res.valid && op.data[TAG_W-1:0] == res.tag) begin
			woke.ready = 1'b1;
			woke.data = res.value;
		end
		return woke;
	endfunction

endpackage

/* logic/c16_isa_pkg.sv */
package c16_isa_pkg;

	// Anything else is illegal
	typedef enum logic [4:0] {
		ADD_IMM = 5'b00000,
		ADD_REG = 5'b00001,
		SUB_IMM = 5'b00010,
		SUB_REG = 5'b00011
	} opcode_e;

	typedef logic [2:0] reg_idx_t;

	// Register plus sign-extended immediate
	typedef struct packed {
		opcode_e    opcode;
		reg_idx_t   dest;
		reg_idx_t   src_a;
		logic [4:0] imm;
	} imm_fmt_t;

	// Register plus register
	typedef struct packed {
		opcode_e    opcode;
		reg_idx_t   dest;
		reg_idx_t   src_a;
		logic [1:0] unused;
		reg_idx_t   src_b;
	} reg_fmt_t;

	// One instruction word, low five bits read either way
	typedef union packed {
		imm_fmt_t i_fmt;
		reg_fmt_t r_fmt;
	} instr_u;

endpackage

/* logic/c16_config.svh */
`ifndef C16_CONFIG_SVH
`define C16_CONFIG_SVH

//////////////////////////////
// Datapath
//////////////////////////////

`define C16_DATA_W 16

// Architectural register file
`define C16_NUM_REGS 8

//////////////////////////////
// Out-of-order window
//////////////////////////////

// Power of two, slot index doubles as the tag
`define C16_ROB_DEPTH 8

`define C16_RS_DEPTH 4

`endif
